//--- logic/dma_rx_cfg.svh
// CPU DMA receive queue configuration
// Widths, FIFO sizes, watchdog timeout and counter width
`ifndef DMA_RX_CFG_SVH
`define DMA_RX_CFG_SVH

`define RX_DATA_WIDTH          32
`define RX_CTRL_WIDTH          4
`define RX_DATA_DEPTH_BITS     6
`define RX_LEN_DEPTH_BITS      3
`define RX_NEARLY_FULL_MARGIN  4
`define RX_WATCHDOG_TIMEOUT    64
`define RX_CNT_WIDTH           16
`define RX_STAGE_NUMBER        4'hf

`endif

//--- logic/dma_rx_pkg.sv
// CPU DMA receive queue types
// Queue word, module header views, length entry and event pulses
`include "dma_rx_cfg.svh"

package dma_rx_pkg;

   localparam int RX_PORT_WIDTH = 6;

   // One word of the data FIFO and of the datapath
   typedef struct packed {
      logic [`RX_CTRL_WIDTH-1:0] ctrl;
      logic [`RX_DATA_WIDTH-1:0] data;
   } rx_word_t;

   typedef struct packed {
      logic [9:0]               word_len;
      logic [RX_PORT_WIDTH-1:0] src_port;
      logic [3:0]               reserved;
      logic [11:0]              byte_len;
   } rx_hdr_t;

   // DMA length word and module header share this layout
   typedef union packed {
      logic [`RX_DATA_WIDTH-1:0] raw;
      rx_hdr_t                   hdr;
   } rx_hdr_u;

   typedef struct packed {
      logic        vld;
      logic [11:0] byte_len;
   } rx_len_t;

   typedef struct packed {
      logic stored;
      logic dropped;
      logic removed;
      logic overrun;
      logic timeout;
   } rx_event_t;

   // Bytes to 32-bit words, rounded up
   function automatic logic [9:0] byte_to_words(input logic [11:0] bytes);
      return bytes[11:2] + {9'd0, |bytes[1:0]};
   endfunction

endpackage

//--- logic/rx_fifo.sv
// Synchronous first-word-fall-through FIFO
// Head entry shows on dout whenever empty is low. Clear empties it
// in one cycle. Nearly full warns a few entries before full.
`include "dma_rx_cfg.svh"

module rx_fifo #(
   parameter int WIDTH      = 36,
   parameter int DEPTH_BITS = 6
) (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  clear,
   input  logic [WIDTH-1:0]      din,
   input  logic                  wr,
   input  logic                  rd,
   output logic [WIDTH-1:0]      dout,
   output logic                  empty,
   output logic                  full,
   output logic                  nearly_full,
   output logic [DEPTH_BITS:0]   count
);

   localparam int DEPTH = 2 ** DEPTH_BITS;

   logic [WIDTH-1:0]      mem [0:DEPTH-1];
   logic [DEPTH_BITS-1:0] wr_ptr;
   logic [DEPTH_BITS-1:0] rd_ptr;
   logic                  wr_ok;
   logic                  rd_ok;

   assign wr_ok = wr && !full;
   assign rd_ok = rd && !empty;

   assign dout        = mem[rd_ptr];
   assign empty       = (count == '0);
   assign full        = (count == (DEPTH_BITS+1)'(DEPTH));
   assign nearly_full = (count >= (DEPTH_BITS+1)'(DEPTH - `RX_NEARLY_FULL_MARGIN));

   always_ff @(posedge clk) begin
      if (wr_ok)
         mem[wr_ptr] <= din;
   end

   always_ff @(posedge clk) begin
      if (reset || clear) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_ok)
            wr_ptr <= wr_ptr + 1'b1;
         if (rd_ok)
            rd_ptr <= rd_ptr + 1'b1;
         // Simultaneous read and write leaves the level alone
         if (wr_ok && !rd_ok)
            count <= count + 1'b1;
         else if (rd_ok && !wr_ok)
            count <= count - 1'b1;
      end
   end

   // Writers must respect full, readers must respect empty
   a_no_write_full: assert property (@(posedge clk) disable iff (reset) wr |-> !full);
   a_no_read_empty: assert property (@(posedge clk) disable iff (reset) rd |-> !empty);

endmodule

//--- logic/dma_rx_input.sv
// DMA write side of the receive queue
// First word of a packet carries the byte length and is not stored.
// Data words are swapped to big-endian and written to the data FIFO,
// and the length entry follows one cycle after the last word.
`include "dma_rx_cfg.svh"

module dma_rx_input (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      clear,
   input  logic                      queue_en,
   input  logic                      dma_wr,
   input  logic                      dma_pkt_vld,
   input  logic [`RX_DATA_WIDTH-1:0] dma_wr_data,
   input  logic [`RX_CTRL_WIDTH-1:0] dma_wr_ctrl,
   input  logic                      data_full,
   output logic                      data_wr,
   output dma_rx_pkg::rx_word_t      data_word,
   output logic                      len_wr,
   output dma_rx_pkg::rx_len_t       len_entry,
   output logic                      overrun,
   output logic                      stored,
   output logic                      dropped,
   output logic [11:0]               last_byte_cnt,
   output logic [9:0]                last_word_cnt
);

   import dma_rx_pkg::*;

   logic    accept;
   logic    in_pkt;
   logic    last_word;
   rx_hdr_u first_word;

   assign first_word.raw = dma_wr_data;

   // Disabled queue ignores DMA writes entirely
   assign accept    = dma_wr && queue_en;
   assign last_word = |dma_wr_ctrl;
   assign data_wr   = accept && in_pkt && !data_full;

   // Host little-endian to datapath big-endian
   always_comb begin
      for (int k = 0; k < `RX_CTRL_WIDTH; k++) begin
         data_word.ctrl[k]        = dma_wr_ctrl[`RX_CTRL_WIDTH-1-k];
         data_word.data[8*k +: 8] = dma_wr_data[`RX_DATA_WIDTH-8-8*k +: 8];
      end
   end

   /////////////////////////////////
   // Packet tracking
   /////////////////////////////////
   always_ff @(posedge clk) begin
      if (reset) begin
         in_pkt        <= 1'b0;
         last_byte_cnt <= '0;
         last_word_cnt <= '0;
         len_wr        <= 1'b0;
         stored        <= 1'b0;
         dropped       <= 1'b0;
         overrun       <= 1'b0;
      end else begin
         if (clear)
            in_pkt <= 1'b0;
         else if (accept && !in_pkt) begin
            in_pkt        <= 1'b1;
            last_byte_cnt <= first_word.hdr.byte_len;
            last_word_cnt <= byte_to_words(first_word.hdr.byte_len);
         end else if (accept && last_word)
            in_pkt <= 1'b0;

         len_wr  <= data_wr && last_word;
         stored  <= data_wr && last_word && dma_pkt_vld;
         dropped <= data_wr && last_word && !dma_pkt_vld;
         // Word lost to a full data FIFO
         overrun <= accept && in_pkt && data_full;
      end
   end

   // Length entry for the packet just finished
   always_ff @(posedge clk) begin
      len_entry.vld      <= dma_pkt_vld;
      len_entry.byte_len <= last_byte_cnt;
   end

endmodule

//--- logic/dma_rx_output.sv
// Receive queue output FSM
// Waits for a length entry, then sends the packet with an optional
// module header in front, or drains an invalid packet silently.
// All datapath outputs are registered.
`include "dma_rx_cfg.svh"

module dma_rx_output #(
   parameter int ENABLE_HEADER = 1,
   parameter int PORT_NUMBER   = 0
) (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      out_rdy,
   input  dma_rx_pkg::rx_word_t      data_word,
   input  logic                      data_empty,
   input  dma_rx_pkg::rx_len_t       len_entry,
   input  logic                      len_empty,
   output logic                      data_rd,
   output logic                      len_rd,
   output logic                      removed,
   output logic [`RX_DATA_WIDTH-1:0] out_data,
   output logic [`RX_CTRL_WIDTH-1:0] out_ctrl,
   output logic                      out_wr
);

   import dma_rx_pkg::*;

   localparam logic [1:0] ST_WAIT = 2'd0;
   localparam logic [1:0] ST_XFER = 2'd1;
   localparam logic [1:0] ST_DROP = 2'd2;

   logic [1:0]                state;
   logic [1:0]                state_nxt;
   logic                      last_word;
   logic                      removed_nxt;
   logic                      out_wr_nxt;
   logic [`RX_DATA_WIDTH-1:0] out_data_nxt;
   logic [`RX_CTRL_WIDTH-1:0] out_ctrl_nxt;
   rx_hdr_u                   hdr_word;

   assign last_word = (data_word.ctrl != '0);

   // Module header built from the pending length entry
   always_comb begin
      hdr_word.hdr.word_len = byte_to_words(len_entry.byte_len);
      hdr_word.hdr.src_port = RX_PORT_WIDTH'(PORT_NUMBER);
      hdr_word.hdr.reserved = '0;
      hdr_word.hdr.byte_len = len_entry.byte_len;
   end

   always_comb begin
      state_nxt    = state;
      data_rd      = 1'b0;
      len_rd       = 1'b0;
      removed_nxt  = 1'b0;
      out_wr_nxt   = 1'b0;
      out_data_nxt = '0;
      out_ctrl_nxt = '0;
      case (state)
         ST_WAIT: begin
            if (out_rdy && !len_empty) begin
               if (!len_entry.vld)
                  state_nxt = ST_DROP;
               else if (ENABLE_HEADER != 0) begin
                  out_data_nxt = hdr_word.raw;
                  out_ctrl_nxt = `RX_STAGE_NUMBER;
                  out_wr_nxt   = 1'b1;
                  state_nxt    = ST_XFER;
               end else if (!data_empty) begin
                  data_rd      = 1'b1;
                  out_data_nxt = data_word.data;
                  out_ctrl_nxt = data_word.ctrl;
                  out_wr_nxt   = 1'b1;
                  // Single-word packet finishes right here
                  if (last_word) begin
                     len_rd      = 1'b1;
                     removed_nxt = 1'b1;
                  end else
                     state_nxt = ST_XFER;
               end
            end
         end
         ST_XFER: begin
            if (out_rdy && !data_empty) begin
               data_rd      = 1'b1;
               out_data_nxt = data_word.data;
               out_ctrl_nxt = data_word.ctrl;
               out_wr_nxt   = 1'b1;
               if (last_word) begin
                  len_rd      = 1'b1;
                  removed_nxt = 1'b1;
                  state_nxt   = ST_WAIT;
               end
            end
         end
         ST_DROP: begin
            // Drain without regard to out_rdy
            if (!data_empty) begin
               data_rd = 1'b1;
               if (last_word) begin
                  len_rd    = 1'b1;
                  state_nxt = ST_WAIT;
               end
            end
         end
         default: state_nxt = ST_WAIT;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state   <= ST_WAIT;
         out_wr  <= 1'b0;
         removed <= 1'b0;
      end else begin
         state   <= state_nxt;
         out_wr  <= out_wr_nxt;
         removed <= removed_nxt;
      end
   end

   always_ff @(posedge clk) begin
      out_data <= out_data_nxt;
      out_ctrl <= out_ctrl_nxt;
   end

endmodule

//--- logic/rx_watchdog.sv
// Receive queue lock-up watchdog
// Data stuck in the queue with no complete packet behind it for the
// configured number of cycles triggers a one-cycle clear.
`include "dma_rx_cfg.svh"

module rx_watchdog (
   input  logic clk,
   input  logic reset,
   input  logic data_wr,
   input  logic data_rd,
   input  logic data_empty,
   input  logic stored,
   input  logic removed,
   output logic clear
);

   localparam int TIMER_WIDTH = $clog2(`RX_WATCHDOG_TIMEOUT + 1);

   logic [TIMER_WIDTH-1:0]         timer;
   logic [`RX_LEN_DEPTH_BITS+1:0]  pkts_in_q;
   logic                           clear_nxt;

   // Stalled data with no complete packet behind it
   assign clear_nxt = (timer == '0) && !data_empty && (pkts_in_q == '0) &&
                      !data_wr && !data_rd;

   always_ff @(posedge clk) begin
      if (reset) begin
         timer     <= TIMER_WIDTH'(`RX_WATCHDOG_TIMEOUT);
         pkts_in_q <= '0;
         clear     <= 1'b0;
      end else begin
         // Any FIFO activity or a clear restarts the count
         if (data_wr || data_rd || clear_nxt)
            timer <= TIMER_WIDTH'(`RX_WATCHDOG_TIMEOUT);
         else if (!data_empty && timer != '0)
            timer <= timer - 1'b1;

         clear <= clear_nxt;

         if (clear)
            pkts_in_q <= '0;
         else if (stored && !removed)
            pkts_in_q <= pkts_in_q + 1'b1;
         else if (removed && !stored)
            pkts_in_q <= pkts_in_q - 1'b1;
      end
   end

   a_clear_single: assert property (@(posedge clk) disable iff (reset) clear |=> !clear);

endmodule

//--- logic/rx_queue_regs.sv
// Receive queue register block
// Saturating event counters, last packet lengths and the enable bit.
// Reads return data one cycle after reg_rd.
`include "dma_rx_cfg.svh"

module rx_queue_regs (
   input  logic                  clk,
   input  logic                  reset,
   input  dma_rx_pkg::rx_event_t events,
   input  logic [11:0]           last_byte_cnt,
   input  logic [9:0]            last_word_cnt,
   input  logic [2:0]            reg_addr,
   input  logic                  reg_rd,
   input  logic                  reg_wr,
   input  logic [31:0]           reg_wr_data,
   output logic [31:0]           reg_rd_data,
   output logic                  queue_en
);

   logic [`RX_CNT_WIDTH-1:0] cnt [0:4];
   logic [4:0]               ev_bits;

   // Bit position matches the counter's address
   assign ev_bits = {events.timeout, events.overrun, events.removed,
                     events.dropped, events.stored};

   //////////////////////////////
   // Counters and control
   //////////////////////////////
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < 5; i++)
            cnt[i] <= '0;
         queue_en <= 1'b1;
      end else begin
         for (int i = 0; i < 5; i++) begin
            if (ev_bits[i] && cnt[i] != '1)
               cnt[i] <= cnt[i] + 1'b1;
         end
         if (reg_wr && reg_addr == 3'd7)
            queue_en <= reg_wr_data[0];
      end
   end

   always_ff @(posedge clk) begin
      if (reset)
         reg_rd_data <= '0;
      else if (reg_rd) begin
         case (reg_addr)
            3'd0, 3'd1, 3'd2, 3'd3, 3'd4: reg_rd_data <= 32'(cnt[reg_addr]);
            3'd5:    reg_rd_data <= {6'd0, last_word_cnt, 4'd0, last_byte_cnt};
            3'd7:    reg_rd_data <= {31'd0, queue_en};
            default: reg_rd_data <= '0;
         endcase
      end
   end

endmodule

//--- logic/cpu_dma_rx_queue.sv
// CPU DMA receive queue, host to datapath
// DMA writes land in a fall-through data FIFO, finished packets are
// listed in a length FIFO and streamed out by the output FSM.
// A watchdog clears stalled partial packets.
`include "dma_rx_cfg.svh"

module cpu_dma_rx_queue #(
   parameter int ENABLE_HEADER = 1,
   parameter int PORT_NUMBER   = 0
) (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      dma_wr,
   input  logic                      dma_pkt_vld,
   input  logic [`RX_DATA_WIDTH-1:0] dma_wr_data,
   input  logic [`RX_CTRL_WIDTH-1:0] dma_wr_ctrl,
   output logic                      dma_nearly_full,
   output logic [`RX_DATA_WIDTH-1:0] out_data,
   output logic [`RX_CTRL_WIDTH-1:0] out_ctrl,
   output logic                      out_wr,
   input  logic                      out_rdy,
   input  logic [2:0]                reg_addr,
   input  logic                      reg_rd,
   input  logic                      reg_wr,
   input  logic [31:0]               reg_wr_data,
   output logic [31:0]               reg_rd_data
);

   import dma_rx_pkg::*;

   rx_word_t    in_word;
   rx_word_t    head_word;
   rx_len_t     len_in;
   rx_len_t     len_head;
   rx_event_t   events;
   logic        data_wr;
   logic        data_rd;
   logic        data_empty;
   logic        data_full;
   logic        data_nearly_full;
   logic        len_wr;
   logic        len_rd;
   logic        len_empty;
   logic        len_nearly_full;
   logic        clear;
   logic        queue_en;
   logic        stored;
   logic        dropped;
   logic        removed;
   logic        overrun;
   logic [11:0] last_byte_cnt;
   logic [9:0]  last_word_cnt;

   dma_rx_input u_input (
      .clk, .reset, .clear, .queue_en,
      .dma_wr, .dma_pkt_vld, .dma_wr_data, .dma_wr_ctrl,
      .data_full, .data_wr, .data_word(in_word),
      .len_wr, .len_entry(len_in),
      .overrun, .stored, .dropped, .last_byte_cnt, .last_word_cnt
   );

   rx_fifo #(.WIDTH($bits(rx_word_t)), .DEPTH_BITS(`RX_DATA_DEPTH_BITS)) data_fifo (
      .clk, .reset, .clear, .din(in_word), .wr(data_wr), .rd(data_rd),
      .dout(head_word), .empty(data_empty), .full(data_full),
      .nearly_full(data_nearly_full), .count()
   );

   rx_fifo #(.WIDTH($bits(rx_len_t)), .DEPTH_BITS(`RX_LEN_DEPTH_BITS)) len_fifo (
      .clk, .reset, .clear, .din(len_in), .wr(len_wr), .rd(len_rd),
      .dout(len_head), .empty(len_empty), .full(),
      .nearly_full(len_nearly_full), .count()
   );

   dma_rx_output #(.ENABLE_HEADER(ENABLE_HEADER), .PORT_NUMBER(PORT_NUMBER)) u_output (
      .clk, .reset, .out_rdy,
      .data_word(head_word), .data_empty, .len_entry(len_head), .len_empty,
      .data_rd, .len_rd, .removed, .out_data, .out_ctrl, .out_wr
   );

   rx_watchdog u_watchdog (
      .clk, .reset, .data_wr, .data_rd, .data_empty, .stored, .removed, .clear
   );

   assign events = '{stored: stored, dropped: dropped, removed: removed,
                     overrun: overrun, timeout: clear};

   rx_queue_regs u_regs (
      .clk, .reset, .events, .last_byte_cnt, .last_word_cnt,
      .reg_addr, .reg_rd, .reg_wr, .reg_wr_data, .reg_rd_data, .queue_en
   );

   // Back-pressure to the DMA engine
   always_ff @(posedge clk) begin
      if (reset)
         dma_nearly_full <= 1'b0;
      else
         dma_nearly_full <= data_nearly_full || len_nearly_full;
   end

endmodule

//--- tests/tb_cpu_dma_rx_queue.sv
// Testbench for the CPU DMA receive queue
// Directed tests drive DMA packets and the register port, collect the
// output stream and compare it with words built from the packet rules.
`include "dma_rx_cfg.svh"

module tb_cpu_dma_rx_queue;

   localparam int PORT_NUMBER    = 5;
   localparam int DATA_DEPTH     = 2 ** `RX_DATA_DEPTH_BITS;
   // The whole run needs about 600 cycles
   localparam int TIMEOUT_CYCLES = 5000;

   logic        clk = 1'b0;
   logic        reset;
   logic        dma_wr;
   logic        dma_pkt_vld;
   logic [31:0] dma_wr_data;
   logic [3:0]  dma_wr_ctrl;
   logic        dma_nearly_full;
   logic [31:0] out_data;
   logic [3:0]  out_ctrl;
   logic        out_wr;
   logic        out_rdy;
   logic [2:0]  reg_addr;
   logic        reg_rd;
   logic        reg_wr;
   logic [31:0] reg_wr_data;
   logic [31:0] reg_rd_data;

   int          errors = 0;
   int          checks = 0;
   int          cycles = 0;
   integer      seed;
   logic        rdy_at_edge = 1'b1;
   logic        nf_seen = 1'b0;
   logic [35:0] got_q[$];
   logic [35:0] exp_q[$];

   cpu_dma_rx_queue #(.ENABLE_HEADER(1), .PORT_NUMBER(PORT_NUMBER)) uut (
      .clk, .reset, .dma_wr, .dma_pkt_vld, .dma_wr_data, .dma_wr_ctrl,
      .dma_nearly_full, .out_data, .out_ctrl, .out_wr, .out_rdy,
      .reg_addr, .reg_rd, .reg_wr, .reg_wr_data, .reg_rd_data
   );

   always #2 clk = ~clk;

   //////////////////////////////
   // Output monitor
   //////////////////////////////
   always @(posedge clk)
      rdy_at_edge <= out_rdy;

   // Sampled mid-cycle, away from the clock edge
   always @(negedge clk) begin
      if (out_wr === 1'b1) begin
         got_q.push_back({out_ctrl, out_data});
         if (!rdy_at_edge) begin
            $display("Error at time %0t: out_wr high after out_rdy was low", $time);
            errors++;
         end
      end
      if (dma_nearly_full === 1'b1)
         nf_seen = 1'b1;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("Error: run stopped after %0d cycles without finishing", cycles);
         $display("Checks: %0d, errors: %0d", checks, errors + 1);
         $display("Simulation failed");
         $finish;
      end
   end

   //////////////////////////////
   // Helpers
   //////////////////////////////
   task automatic check_value(input string name, input logic [35:0] got,
                              input logic [35:0] exp);
      checks++;
      if (got !== exp) begin
         $display("Mismatch at time %0t: %s expected %h got %h", $time, name, exp, got);
         errors++;
      end
   endtask

   task automatic reset_dut();
      @(negedge clk);
      reset = 1'b1;
      repeat (3) @(negedge clk);
      // Output is idle under reset
      got_q.delete();
      exp_q.delete();
      nf_seen = 1'b0;
      reset   = 1'b0;
   endtask

   task automatic drive_word(input logic vld, input logic [31:0] data, input logic [3:0] ctrl);
      @(negedge clk);
      dma_wr      = 1'b1;
      dma_pkt_vld = vld;
      dma_wr_data = data;
      dma_wr_ctrl = ctrl;
   endtask

   // Length word, then random data words; shown adds the expected output
   task automatic send_packet(input int nbytes, input logic vld, input logic shown);
      int          nwords;
      int          i;
      logic [31:0] word;
      logic [3:0]  ctrl;
      nwords = (nbytes + 3) / 4;
      if (shown)
         exp_q.push_back({4'hf, 10'(nwords), 6'(PORT_NUMBER), 4'd0, 12'(nbytes)});
      drive_word(vld, 32'(nbytes), 4'd0);
      for (i = 0; i < nwords; i++) begin
         word = $random(seed);
         // Last word flags its final valid byte, little-endian
         ctrl = (i == nwords - 1) ? 4'b0001 << ((nbytes - 1) % 4) : 4'd0;
         drive_word(vld, word, ctrl);
         if (shown)
            exp_q.push_back({ctrl[0], ctrl[1], ctrl[2], ctrl[3],
                             word[7:0], word[15:8], word[23:16], word[31:24]});
      end
      @(negedge clk);
      dma_wr      = 1'b0;
      dma_wr_ctrl = 4'd0;
   endtask

   task automatic read_reg(input logic [2:0] addr, output logic [31:0] data);
      @(negedge clk);
      reg_addr = addr;
      reg_rd   = 1'b1;
      @(negedge clk);
      reg_rd = 1'b0;
      data   = reg_rd_data;
   endtask

   task automatic write_reg(input logic [2:0] addr, input logic [31:0] data);
      @(negedge clk);
      reg_addr    = addr;
      reg_wr_data = data;
      reg_wr      = 1'b1;
      @(negedge clk);
      reg_wr = 1'b0;
   endtask

   task automatic check_reg(input logic [2:0] addr, input logic [31:0] exp, input string name);
      logic [31:0] value;
      read_reg(addr, value);
      check_value($sformatf("reg_rd_data[%0d] %s", addr, name), value, exp);
   endtask

   task automatic expect_output(input int limit);
      int waited;
      waited = 0;
      while (got_q.size() < exp_q.size() && waited < limit) begin
         @(posedge clk);
         waited++;
      end
      // Room for stray words behind the last packet
      repeat (10) @(posedge clk);
      checks++;
      if (got_q.size() != exp_q.size()) begin
         $display("Error at time %0t: %0d output words seen, %0d expected",
                  $time, got_q.size(), exp_q.size());
         errors++;
      end else begin
         foreach (exp_q[i])
            check_value($sformatf("out_ctrl/out_data word %0d", i), got_q[i], exp_q[i]);
      end
      got_q.delete();
      exp_q.delete();
   endtask

   task automatic expect_no_output(input string when);
      @(posedge clk);
      checks++;
      if (got_q.size() != 0) begin
         $display("Error at time %0t: %0d output words appeared %s", $time, got_q.size(), when);
         errors++;
      end
      got_q.delete();
   endtask

   //////////////////////////////
   // Tests
   //////////////////////////////
   task automatic good_packets_with_header();
      reset_dut();
      send_packet(13, 1'b1, 1'b1);
      send_packet(8, 1'b1, 1'b1);
      expect_output(200);
      check_reg(3'd0, 32'd2, "stored");
      check_reg(3'd2, 32'd2, "removed");
      check_reg(3'd5, {6'd0, 10'd2, 4'd0, 12'd8}, "last lengths");
   endtask

   task automatic invalid_packet_dropped();
      reset_dut();
      send_packet(12, 1'b0, 1'b0);
      send_packet(7, 1'b1, 1'b1);
      expect_output(200);
      check_reg(3'd1, 32'd1, "dropped");
      check_reg(3'd0, 32'd1, "stored");
   endtask

   task automatic back_pressure();
      int          waited;
      logic [31:0] rnd;
      reset_dut();
      @(negedge clk);
      out_rdy = 1'b0;
      send_packet(17, 1'b1, 1'b1);
      send_packet(26, 1'b1, 1'b1);
      repeat (20) @(posedge clk);
      expect_no_output("while out_rdy was held low");
      waited = 0;
      while (got_q.size() < exp_q.size() && waited < 400) begin
         @(negedge clk);
         rnd     = $random(seed);
         out_rdy = rnd[0];
         waited++;
      end
      @(negedge clk);
      out_rdy = 1'b1;
      expect_output(100);
   endtask

   task automatic overrun_fill();
      reset_dut();
      @(negedge clk);
      out_rdy = 1'b0;
      // Driver ignores dma_nearly_full so the data FIFO overflows
      send_packet(160, 1'b1, 1'b0);
      send_packet(160, 1'b1, 1'b0);
      repeat (5) @(posedge clk);
      checks++;
      if (!nf_seen) begin
         $display("Error at time %0t: dma_nearly_full never went high while filling", $time);
         errors++;
      end
      check_reg(3'd3, 32'(2 * 40 - DATA_DEPTH), "overrun");
      check_reg(3'd0, 32'd1, "stored");
      expect_no_output("with out_rdy held low");
      reset_dut();
      @(negedge clk);
      out_rdy = 1'b1;
   endtask

   task automatic watchdog_clear();
      int          i;
      logic [31:0] word;
      reset_dut();
      // Length word announces 10 data words, only 5 arrive
      drive_word(1'b1, 32'd40, 4'd0);
      for (i = 0; i < 5; i++) begin
         word = $random(seed);
         drive_word(1'b1, word, 4'd0);
      end
      @(negedge clk);
      dma_wr = 1'b0;
      repeat (100) @(posedge clk);
      check_reg(3'd4, 32'd1, "timeout");
      expect_no_output("from the stalled packet");
      send_packet(11, 1'b1, 1'b1);
      expect_output(200);
      check_reg(3'd2, 32'd1, "removed");
   endtask

   task automatic enable_control();
      reset_dut();
      write_reg(3'd7, 32'd0);
      check_reg(3'd7, 32'd0, "control");
      send_packet(9, 1'b1, 1'b0);
      repeat (30) @(posedge clk);
      expect_no_output("while the queue was disabled");
      check_reg(3'd0, 32'd0, "stored");
      write_reg(3'd7, 32'd1);
      send_packet(9, 1'b1, 1'b1);
      expect_output(200);
      check_reg(3'd0, 32'd1, "stored");
   endtask

   initial begin
      seed        = 32'hfca23416;
      reset       = 1'b1;
      dma_wr      = 1'b0;
      dma_pkt_vld = 1'b0;
      dma_wr_data = 32'd0;
      dma_wr_ctrl = 4'd0;
      out_rdy     = 1'b1;
      reg_addr    = 3'd0;
      reg_rd      = 1'b0;
      reg_wr      = 1'b0;
      reg_wr_data = 32'd0;

      good_packets_with_header();
      invalid_packet_dropped();
      back_pressure();
      overrun_fill();
      watchdog_clear();
      enable_control();

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

//--- tb.f
+incdir+logic
logic/dma_rx_pkg.sv
logic/rx_fifo.sv
logic/dma_rx_input.sv
logic/dma_rx_output.sv
logic/rx_watchdog.sv
logic/rx_queue_regs.sv
logic/cpu_dma_rx_queue.sv
tests/tb_cpu_dma_rx_queue.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the DMA receive queue testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f tb.f \
   --top-module tb_cpu_dma_rx_queue -Mdir obj_dir

result=$(./obj_dir/Vtb_cpu_dma_rx_queue) || true
echo "$result"

if echo "$result" | grep -qx "Simulation passed"; then
   exit 0
fi
exit 1
